//--- source/vdc_cfg_pkg.sv
package vdc_cfg_pkg;

	// CRTC register numbers as seen through the address latch
	typedef enum logic [5:0] {
		R_HT  = 6'd0,	// Horizontal total minus 1
		R_HD  = 6'd1,	// Horizontal displayed
		R_HP  = 6'd2,	// Horizontal sync position
		R_SW  = 6'd3,	// Vertical and horizontal sync widths
		R_VT  = 6'd4,	// Vertical total minus 1
		R_VD  = 6'd6,	// Vertical displayed
		R_VP  = 6'd7,	// Vertical sync position
		R_CM  = 6'd10,	// Cursor mode in bits 6:5
		R_CPH = 6'd14,	// Cursor position high byte
		R_CPL = 6'd15,	// Cursor position low byte
		R_LPV = 6'd16,	// Light pen row, read only
		R_LPH = 6'd17,	// Light pen column, read only
		R_RVS = 6'd24,	// Reverse screen in bit 6
		R_COL = 6'd26,	// Foreground and background colour
		R_POL = 6'd37	// Sync polarity, 8568 only
	} reg_idx_e;

	// Live register fields used by the video side
	typedef struct packed {
		logic [7:0]  ht;	// R0
		logic [7:0]  hd;	// R1
		logic [7:0]  hp;	// R2
		logic [3:0]  vw;	// R3[7:4]
		logic [3:0]  hw;	// R3[3:0]
		logic [7:0]  vt;	// R4
		logic [7:0]  vd;	// R6
		logic [7:0]  vp;	// R7
		logic [1:0]  cm;	// R10[6:5]
		logic [15:0] cp;	// R14/R15
		logic        rvs;	// R24[6]
		logic [3:0]  fg;	// R26[7:4]
		logic [3:0]  bg;	// R26[3:0]
		logic        hspol;	// R37[7]
		logic        vspol;	// R37[6]
	} crtc_cfg_t;

	localparam logic [1:0] VER_8568 = 2'd2;	// First chip revision with R37

endpackage

//--- source/vdc_beam_pkg.sv
package vdc_beam_pkg;

	// Beam position in character cells and scan lines
	typedef struct packed {
		logic [7:0]  col;	// Character column
		logic [7:0]  row;	// Character row
		logic [4:0]  line;	// Scan line inside the row
		logic [2:0]  pixel;	// Pixel inside the cell
		logic [15:0] cell_addr;	// Row times hd plus col
	} beam_t;

	// Raster flags, all derived from the current counters
	typedef struct packed {
		logic pix_en;	// One clock per pixel
		logic hsync;
		logic vsync;
		logic hblank;	// Column at or beyond hd
		logic vblank;	// Row at or beyond vd
		logic frame;	// Single strobe at frame start
		logic disp;	// Inside display window
	} raster_t;

	// Blink phases driven from the frame counter
	typedef struct packed {
		logic slow;	// Toggles every 16 frames
		logic fast;	// Toggles every 8 frames
	} blink_t;

endpackage

//--- source/vdc_bus_regs.sv
`timescale 1ns/1ns

module vdc_bus_regs #(
	parameter logic [1:0] VERSION = 2'd2	// Chip revision reported in status
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cs,	// Chip select
	input  logic                   rs,	// Register select, low is address/status
	input  logic                   we,	// Write strobe
	input  logic                   lp_n,	// Light pen level
	input  logic [7:0]             db_in,
	input  vdc_beam_pkg::beam_t    beam,
	input  vdc_beam_pkg::raster_t  ras,
	output logic [7:0]             db_out,
	output vdc_cfg_pkg::crtc_cfg_t cfg
);

	import vdc_cfg_pkg::*;

	logic [5:0] sel;	// Selected register index
	logic [7:0] lpv;	// R16 light pen row latch
	logic [7:0] lph;	// R17 light pen column latch
	logic       lp_flag;	// Status bit 6
	logic       lp_q;	// Previous light pen sample
	logic       lp_edge;	// Rising edge of lp_n
	logic       lp_take;	// Edge while flag is clear
	logic       lp_rd;	// Read of R16 or R17
	logic       wr_addr;
	logic       wr_data;
	logic       rd_any;
	logic       has_r37;	// Polarity register present
	logic [7:0] rd_word;	// Register readback
	logic [7:0] status;	// Status word for rs low

	assign has_r37 = (VERSION == VER_8568);
	assign wr_addr = cs & we & ~rs;	// Address latch write
	assign wr_data = cs & we & rs;	// Data write to selected register
	assign rd_any  = cs & ~we;
	assign lp_rd   = rd_any & rs & ((sel == R_LPV) | (sel == R_LPH));
	assign lp_edge = ~lp_q & lp_n;
	assign lp_take = lp_edge & ~lp_flag;	// Latch only once until read

	// Ready is always set since there is no RAM engine
	assign status = {1'b1, lp_flag, ras.vblank, 3'b000, VERSION};

	// Readback with unimplemented bits forced high
	always_comb begin
		case (sel)
			R_HT:    rd_word = cfg.ht;
			R_HD:    rd_word = cfg.hd;
			R_HP:    rd_word = cfg.hp;
			R_SW:    rd_word = {cfg.vw, cfg.hw};
			R_VT:    rd_word = cfg.vt;
			R_VD:    rd_word = cfg.vd;
			R_VP:    rd_word = cfg.vp;
			R_CM:    rd_word = {1'b1, cfg.cm, 5'b11111};	// Cursor start line not kept
			R_CPH:   rd_word = cfg.cp[15:8];
			R_CPL:   rd_word = cfg.cp[7:0];
			R_LPV:   rd_word = lpv;
			R_LPH:   rd_word = lph;
			R_RVS:   rd_word = {1'b1, cfg.rvs, 6'b111111};
			R_COL:   rd_word = {cfg.fg, cfg.bg};
			R_POL:   rd_word = has_r37 ? {cfg.hspol, cfg.vspol, 6'b111111} : 8'hFF;
			default: rd_word = 8'hFF;	// Unlisted index
		endcase
	end

	// Address latch and writable fields
	always_ff @(posedge clk) begin
		if (reset) begin
			sel <= '0;
			cfg <= '0;
		end else if (wr_addr) begin
			sel <= db_in[5:0];
		end else if (wr_data) begin
			case (sel)
				R_HT:  cfg.ht <= db_in;
				R_HD:  cfg.hd <= db_in;
				R_HP:  cfg.hp <= db_in;
				R_SW: begin
					cfg.vw <= db_in[7:4];
					cfg.hw <= db_in[3:0];
				end
				R_VT:  cfg.vt <= db_in;
				R_VD:  cfg.vd <= db_in;
				R_VP:  cfg.vp <= db_in;
				R_CM:  cfg.cm <= db_in[6:5];
				R_CPH: cfg.cp[15:8] <= db_in;
				R_CPL: cfg.cp[7:0] <= db_in;
				R_RVS: cfg.rvs <= db_in[6];
				R_COL: begin
					cfg.fg <= db_in[7:4];
					cfg.bg <= db_in[3:0];
				end
				R_POL: begin
					if (has_r37) begin	// Ignored on older chips
						cfg.hspol <= db_in[7];
						cfg.vspol <= db_in[6];
					end
				end
				default: ;	// Read-only or absent
			endcase
		end
	end

	// Read data holds until the next read
	always_ff @(posedge clk) begin
		if (reset) begin
			db_out <= '0;
		end else if (rd_any) begin
			db_out <= rs ? rd_word : status;
		end
	end

	// Light pen capture
	always_ff @(posedge clk) begin
		if (reset) begin
			lp_q    <= 1'b1;	// Idle high so reset gives no edge
			lp_flag <= 1'b0;
			lpv     <= '0;
			lph     <= '0;
		end else begin
			lp_q <= lp_n;
			if (lp_rd) begin
				lp_flag <= 1'b0;	// Cleared by either pen register
			end
			if (lp_take) begin
				lpv     <= beam.row;
				lph     <= beam.col;
				lp_flag <= 1'b1;
			end
		end
	end

endmodule

//--- source/vdc_crtc_timing.sv
`timescale 1ns/1ns

module vdc_crtc_timing #(
	parameter int PIX_DIV = 2,	// Clocks per pixel
	parameter int CHAR_W  = 8,	// Pixels per cell
	parameter int CHAR_H  = 8	// Lines per row
) (
	input  logic                   clk,
	input  logic                   reset,
	input  vdc_cfg_pkg::crtc_cfg_t cfg,
	output vdc_beam_pkg::beam_t    beam,
	output vdc_beam_pkg::raster_t  ras,
	output vdc_beam_pkg::blink_t   blink
);

	localparam int               DIV_W     = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_LAST  = DIV_W'(PIX_DIV - 1);
	localparam logic [2:0]       PIX_LAST  = 3'(CHAR_W - 1);
	localparam logic [4:0]       LINE_LAST = 5'(CHAR_H - 1);

	logic [DIV_W-1:0] div_cnt;	// Clock divider
	logic             pix_en;
	logic [2:0]       pixel;
	logic [7:0]       col;
	logic [4:0]       line;
	logic [7:0]       row;
	logic [15:0]      row_base;	// Cell address of column 0 in this row
	logic [4:0]       frame_cnt;	// Blink source
	logic             end_cell;
	logic             end_line;
	logic             end_row;
	logic             end_frame;
	logic [8:0]       hs_end;	// First column after hsync
	logic [8:0]       vs_end;	// First row after vsync
	logic             hsync;
	logic             vsync;
	logic             hblank;
	logic             vblank;
	logic             frame;

	assign pix_en    = (div_cnt == DIV_LAST);
	assign end_cell  = pix_en & (pixel == PIX_LAST);
	assign end_line  = end_cell & (col >= cfg.ht);	// Also catches ht lowered mid-line
	assign end_row   = end_line & (line == LINE_LAST);
	assign end_frame = end_row & (row >= cfg.vt);

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt   <= '0;
			pixel     <= '0;
			col       <= '0;
			line      <= '0;
			row       <= '0;
			row_base  <= '0;
			frame_cnt <= '0;
		end else begin
			div_cnt <= pix_en ? '0 : div_cnt + 1'b1;
			if (end_cell) pixel <= '0;
			else if (pix_en) pixel <= pixel + 1'b1;
			if (end_line) col <= '0;
			else if (end_cell) col <= col + 1'b1;
			if (end_row) line <= '0;
			else if (end_line) line <= line + 1'b1;
			if (end_frame) begin
				row      <= '0;
				row_base <= '0;
			end else if (end_row) begin
				row      <= row + 1'b1;
				row_base <= row_base + {8'd0, cfg.hd};	// Step one row of cells
			end
			if (frame) frame_cnt <= frame_cnt + 1'b1;
		end
	end

	// Sync windows, widened to avoid wrap at 255
	assign hs_end = {1'b0, cfg.hp} + {5'd0, cfg.hw};
	assign vs_end = {1'b0, cfg.vp} + {5'd0, cfg.vw};
	assign hsync  = (col >= cfg.hp) & ({1'b0, col} < hs_end);
	assign vsync  = (row >= cfg.vp) & ({1'b0, row} < vs_end);
	assign hblank = (col >= cfg.hd);
	assign vblank = (row >= cfg.vd);
	assign frame  = pix_en & (pixel == '0) & (col == '0) & (line == '0) & (row == '0);

	assign beam = '{
		col:       col,
		row:       row,
		line:      line,
		pixel:     pixel,
		cell_addr: row_base + {8'd0, col}
	};

	assign ras = '{
		pix_en: pix_en,
		hsync:  hsync,
		vsync:  vsync,
		hblank: hblank,
		vblank: vblank,
		frame:  frame,
		disp:   ~hblank & ~vblank
	};

	assign blink = '{slow: frame_cnt[4], fast: frame_cnt[3]};	// 16 and 8 frame phases

endmodule

//--- source/vdc_pixel_out.sv
`timescale 1ns/1ns

module vdc_pixel_out #(
	parameter logic [1:0] VERSION = 2'd2	// Polarity only on 8568
) (
	input  logic                   clk,
	input  logic                   reset,
	input  vdc_cfg_pkg::crtc_cfg_t cfg,
	input  vdc_beam_pkg::beam_t    beam,
	input  vdc_beam_pkg::raster_t  ras,
	input  vdc_beam_pkg::blink_t   blink,
	output logic                   hsync,
	output logic                   vsync,
	output logic                   blank,
	output logic                   frame,
	output logic [3:0]             rgbi
);

	import vdc_cfg_pkg::*;

	logic       pol_en;	// R37 present
	logic       cur_cell;	// Beam is on cursor cell
	logic       cur_vis;	// Cursor shown in this frame phase
	logic [3:0] fg_c;	// Foreground after reverse
	logic [3:0] bg_c;	// Background after reverse
	logic [3:0] colour;

	assign pol_en   = (VERSION == VER_8568);
	assign cur_cell = (beam.cell_addr == cfg.cp);

	always_comb begin
		case (cfg.cm)
			2'd0:    cur_vis = 1'b1;	// Steady
			2'd1:    cur_vis = 1'b0;	// Off
			2'd2:    cur_vis = blink.fast;
			default: cur_vis = blink.slow;
		endcase
	end

	assign fg_c = cfg.rvs ? cfg.bg : cfg.fg;	// Reverse swaps the pair
	assign bg_c = cfg.rvs ? cfg.fg : cfg.bg;

	// Black outside the window, cursor cell takes foreground
	assign colour = !ras.disp ? 4'h0 : ((cur_cell & cur_vis) ? fg_c : bg_c);

	// All video outputs leave on the same edge
	always_ff @(posedge clk) begin
		if (reset) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			blank <= 1'b0;
			frame <= 1'b0;
			rgbi  <= 4'h0;
		end else begin
			hsync <= ras.hsync ^ (pol_en & cfg.hspol);
			vsync <= ras.vsync ^ (pol_en & cfg.vspol);
			blank <= ras.hblank | ras.vblank;
			frame <= ras.frame;
			rgbi  <= colour;
		end
	end

endmodule

//--- source/vdc_top.sv
`timescale 1ns/1ns

module vdc_top #(
	parameter logic [1:0] VERSION = 2'd2,	// 2 is the 8568
	parameter int         PIX_DIV = 2,	// Clocks per pixel
	parameter int         CHAR_W  = 8,	// Pixels per cell
	parameter int         CHAR_H  = 8	// Lines per row
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       cs,
	input  logic       rs,
	input  logic       we,
	input  logic       lp_n,
	input  logic [7:0] db_in,
	output logic [7:0] db_out,
	output logic       hsync,
	output logic       vsync,
	output logic       blank,
	output logic       frame,
	output logic [3:0] rgbi
);

	import vdc_cfg_pkg::*;
	import vdc_beam_pkg::*;

	crtc_cfg_t cfg;	// Register fields to both video stages
	beam_t     beam;	// Counter state
	raster_t   ras;	// Unregistered raster flags
	blink_t    blink;

	vdc_bus_regs #(
		.VERSION(VERSION)
	) u_regs (
		.clk(clk), .reset(reset),
		.cs(cs), .rs(rs), .we(we), .lp_n(lp_n),
		.db_in(db_in), .beam(beam), .ras(ras),
		.db_out(db_out), .cfg(cfg)
	);

	vdc_crtc_timing #(
		.PIX_DIV(PIX_DIV), .CHAR_W(CHAR_W), .CHAR_H(CHAR_H)
	) u_timing (
		.clk(clk), .reset(reset), .cfg(cfg),
		.beam(beam), .ras(ras), .blink(blink)
	);

	vdc_pixel_out #(
		.VERSION(VERSION)
	) u_pixel (
		.clk(clk), .reset(reset), .cfg(cfg),
		.beam(beam), .ras(ras), .blink(blink),
		.hsync(hsync), .vsync(vsync), .blank(blank),
		.frame(frame), .rgbi(rgbi)
	);

endmodule

//--- test/vdc_tb.sv
`timescale 1ns/1ns

module vdc_tb;

	import vdc_cfg_pkg::*;

	localparam int PIX_DIV = 2;	// DUT defaults
	localparam int CHAR_W  = 8;
	localparam int CHAR_H  = 8;
	localparam int HT = 4;	// Small test raster of 5 columns
	localparam int HD = 3;
	localparam int HP = 3;
	localparam int HW = 1;
	localparam int VT = 1;	// Two rows with the second one blank
	localparam int VD = 1;
	localparam int VP = 1;
	localparam int VW = 1;
	localparam logic [3:0] FG = 4'hE;
	localparam logic [3:0] BG = 4'h1;
	localparam int CP = 1;	// Cursor on row 0 column 1
	localparam int LINE_CLKS  = (HT + 1) * CHAR_W * PIX_DIV;
	localparam int FRAME_CLKS = LINE_CLKS * (VT + 1) * CHAR_H;
	localparam int N_STEPS = 31;
	localparam int LIMIT = 2 * (N_STEPS * 8 + 3 * FRAME_CLKS);	// Eight clocks per step at most
	localparam logic [1:0] OP_W  = 2'd0;
	localparam logic [1:0] OP_R  = 2'd1;
	localparam logic [1:0] OP_WR = 2'd2;

	typedef struct packed {
		logic [1:0] op;	// Write, read or both
		logic [5:0] idx;
		logic [7:0] data;
		logic [7:0] exp;	// Expected readback
	} step_t;

	localparam logic [23:0] STEPS [0:N_STEPS-1] = '{
		{OP_WR, 6'd0, 8'h55, 8'h55}, {OP_WR, 6'd1, 8'hAA, 8'hAA}, {OP_WR, 6'd2, 8'h3C, 8'h3C},
		{OP_WR, 6'd3, 8'hA5, 8'hA5}, {OP_WR, 6'd4, 8'h81, 8'h81}, {OP_WR, 6'd6, 8'h42, 8'h42},
		{OP_WR, 6'd7, 8'h24, 8'h24}, {OP_WR, 6'd10, 8'h40, 8'hDF}, {OP_WR, 6'd14, 8'h12, 8'h12},
		{OP_WR, 6'd15, 8'h34, 8'h34}, {OP_WR, 6'd24, 8'h40, 8'hFF}, {OP_WR, 6'd24, 8'h00, 8'hBF},
		{OP_WR, 6'd26, 8'h5A, 8'h5A}, {OP_WR, 6'd37, 8'hC0, 8'hFF}, {OP_WR, 6'd37, 8'h00, 8'h3F},
		{OP_R, 6'd5, 8'h00, 8'hFF}, {OP_R, 6'd63, 8'h00, 8'hFF}, {OP_R, 6'd16, 8'h00, 8'h00},
		{OP_R, 6'd17, 8'h00, 8'h00}, {OP_W, 6'd0, 8'(HT), 8'h00}, {OP_W, 6'd1, 8'(HD), 8'h00},
		{OP_W, 6'd2, 8'(HP), 8'h00}, {OP_W, 6'd3, {4'(VW), 4'(HW)}, 8'h00},
		{OP_W, 6'd4, 8'(VT), 8'h00}, {OP_W, 6'd6, 8'(VD), 8'h00}, {OP_W, 6'd7, 8'(VP), 8'h00},
		{OP_W, 6'd14, 8'h00, 8'h00}, {OP_W, 6'd15, 8'(CP), 8'h00}, {OP_W, 6'd26, {FG, BG}, 8'h00},
		{OP_W, 6'd10, 8'h00, 8'h00}, {OP_W, 6'd24, 8'h00, 8'h00}
	};

	logic clk, reset, cs, rs, we, lp_n;
	logic [7:0] db_in, db_out;
	logic hsync, vsync, blank, frame;
	logic [3:0] rgbi;
	int cyc, last_frame, errors, checks, test_err;
	logic [31:0] lfsr;

	vdc_top uut (
		.clk(clk), .reset(reset), .cs(cs), .rs(rs), .we(we), .lp_n(lp_n),
		.db_in(db_in), .db_out(db_out), .hsync(hsync), .vsync(vsync),
		.blank(blank), .frame(frame), .rgbi(rgbi)
	);

	always #2 clk = ~clk;

	// Cycle count, last frame strobe and run limit
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (frame) last_frame <= cyc;
		if (cyc >= LIMIT) begin
			$display("Timeout after %0d clocks, the DUT never finished the test sequence", cyc);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic check_val(input string name, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			$display("[FAIL] t=%0t %s expected 'h%0h got 'h%0h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic report(input int num, input string what);
		$display("Test %0d %s: %0d errors", num, what, errors - test_err);
		test_err = errors;
	endtask

	// One strobe cycle with data sampled right after release
	task automatic bus_cycle(input logic rs_v, input logic we_v, input logic [7:0] d,
			output logic [7:0] q);
		@(posedge clk);
		#1 cs = 1'b1;
		rs = rs_v;
		we = we_v;
		db_in = d;
		@(posedge clk);
		#1 cs = 1'b0;
		we = 1'b0;
		q = db_out;
	endtask

	task automatic reg_write(input logic [5:0] idx, input logic [7:0] d);
		logic [7:0] q;
		bus_cycle(1'b0, 1'b1, {2'b00, idx}, q);	// Address latch
		bus_cycle(1'b1, 1'b1, d, q);
	endtask

	task automatic reg_read(input logic [5:0] idx, output logic [7:0] q);
		bus_cycle(1'b0, 1'b1, {2'b00, idx}, q);
		bus_cycle(1'b1, 1'b0, 8'h00, q);
	endtask

	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int b = 0; b < n; b++) begin
			v = (v << 1) | lfsr[0];
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);	// Galois step
		end
		return v;
	endfunction

	// Beam model in clocks since the frame pixel
	function automatic int k_now();
		return (cyc - last_frame) % FRAME_CLKS;
	endfunction

	function automatic int col_at(input int k);
		return (((k + PIX_DIV - 1) / PIX_DIV) / CHAR_W) % (HT + 1);
	endfunction

	function automatic int row_at(input int k);
		return (((k + PIX_DIV - 1) / PIX_DIV) / (CHAR_W * (HT + 1) * CHAR_H)) % (VT + 1);
	endfunction

	function automatic logic blank_at(input int k);
		return (col_at(k) >= HD) || (row_at(k) >= VD);
	endfunction

	function automatic logic [3:0] expect_rgbi(input int k, input logic [1:0] cm, input logic rvs);
		logic [3:0] f, b;
		f = rvs ? BG : FG;	// Reverse swaps
		b = rvs ? FG : BG;
		if (blank_at(k)) return 4'h0;
		if ((row_at(k) * HD + col_at(k) == CP) && cm == 2'd0) return f;
		return b;
	endfunction

	task automatic wait_k(input int target);
		do begin
			@(posedge clk);
			#1;
		end while (k_now() != target);
	endtask

	task automatic wait_edge(input bit use_v, input logic lvl, output int at);
		logic prev, cur;
		cur = use_v ? vsync : hsync;
		do begin
			prev = cur;
			@(posedge clk);
			#1 cur = use_v ? vsync : hsync;
		end while (!(cur == lvl && prev != lvl));
		at = cyc;
	endtask

	task automatic measure_sync();
		int r1, f1, r2;
		wait_edge(1'b0, 1'b1, r1);
		wait_edge(1'b0, 1'b0, f1);
		wait_edge(1'b0, 1'b1, r2);
		check_val("hsync period", r2 - r1, LINE_CLKS);
		check_val("hsync high", f1 - r1, HW * CHAR_W * PIX_DIV);
		wait_edge(1'b1, 1'b1, r1);
		wait_edge(1'b1, 1'b1, r2);
		check_val("vsync period", r2 - r1, FRAME_CLKS);
	endtask

	task automatic scan_frame(input logic [1:0] cm, input logic rvs);
		int k;
		repeat (FRAME_CLKS) begin
			@(posedge clk);
			#1 k = k_now();
			check_val("rgbi", rgbi, expect_rgbi(k, cm, rvs));
			check_val("blank", blank, blank_at(k));
			check_val("frame", frame, k == 0);	// One strobe per frame period
		end
	endtask

	initial begin
		step_t st;
		logic [7:0] q;
		int d, kl, exp_row, exp_col;
		clk = 0;
		reset = 1;
		cs = 0;
		rs = 0;
		we = 0;
		lp_n = 1;
		db_in = 0;
		cyc = 0;
		last_frame = 0;
		errors = 0;
		checks = 0;
		test_err = 0;
		lfsr = 32'h5f0e;
		repeat (4) @(posedge clk);
		#1 reset = 0;
		for (int i = 0; i < N_STEPS; i++) begin
			st = STEPS[i];
			if (st.op != OP_R) reg_write(st.idx, st.data);
			if (st.op != OP_W) begin
				reg_read(st.idx, q);
				check_val($sformatf("db_out R%0d", st.idx), q, st.exp);
			end
		end
		report(1, "register readback");
		do begin
			@(posedge clk);
			#1;
		end while (!frame);	// Raster now regular
		wait_k(4);
		bus_cycle(1'b0, 1'b0, 8'h00, q);
		check_val("status", q, {1'b1, 1'b0, 1'b0, 3'b000, 2'd2});
		check_val("hsync idle", hsync, 0);
		check_val("vsync idle", vsync, 0);
		reg_write(R_POL, 8'hC0);
		repeat (2) @(posedge clk);
		#1 check_val("hsync inverted", hsync, 1);	// Still column 0 of row 0
		check_val("vsync inverted", vsync, 1);
		reg_write(R_POL, 8'h00);
		wait_k(FRAME_CLKS / 2 + 4);
		bus_cycle(1'b0, 1'b0, 8'h00, q);
		check_val("status", q, {1'b1, 1'b0, 1'b1, 3'b000, 2'd2});	// Row 1 is vblank
		report(2, "status and sync polarity");
		fork
			measure_sync();
			begin
				scan_frame(2'd0, 1'b0);
				reg_write(R_RVS, 8'h40);
				scan_frame(2'd0, 1'b1);
				reg_write(R_RVS, 8'h00);
				reg_write(R_CM, 8'h20);	// Cursor off
				scan_frame(2'd1, 1'b0);
			end
		join
		report(3, "raster timing and colour");
		lp_n = 0;
		d = take_bits(8) + 4;
		repeat (d) @(posedge clk);
		#1 lp_n = 1;
		kl = (k_now() + 1) % FRAME_CLKS;	// Latched on the next edge
		exp_row = row_at(kl);
		exp_col = col_at(kl);
		@(posedge clk);
		#1 lp_n = 0;
		bus_cycle(1'b0, 1'b0, 8'h00, q);
		check_val("status[6]", q[6], 1);
		d = take_bits(8) + 4;
		repeat (d) @(posedge clk);
		#1 lp_n = 1;	// Second edge while flag is set
		reg_read(R_LPV, q);
		check_val("R16", q, exp_row);
		assert (q <= VT) else begin
			$display("Light pen row %0d lies outside the vertical total", q);
			errors++;
		end
		bus_cycle(1'b0, 1'b0, 8'h00, q);
		check_val("status[6]", q[6], 0);
		reg_read(R_LPH, q);
		check_val("R17", q, exp_col);
		assert (q <= HT) else begin
			$display("Light pen column %0d lies outside the horizontal total", q);
			errors++;
		end
		report(4, "light pen");
		$display("Done: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- sim.f
source/vdc_cfg_pkg.sv
source/vdc_beam_pkg.sv
source/vdc_bus_regs.sv
source/vdc_crtc_timing.sv
source/vdc_pixel_out.sv
source/vdc_top.sv
test/vdc_tb.sv

//--- Bender.yml
package:
  name: vdc

sources:
  - source/vdc_cfg_pkg.sv
  - source/vdc_beam_pkg.sv
  - source/vdc_bus_regs.sv
  - source/vdc_crtc_timing.sv
  - source/vdc_pixel_out.sv
  - source/vdc_top.sv
  - target: test
    files:
      - test/vdc_tb.sv
